/* bf16_cast_pkg.sv */
package bf16_cast_pkg;

	// bfloat16 field widths
	localparam int BF16_EXP_WIDTH = 8;
	localparam int BF16_MANT_WIDTH = 7;

	// widest integer the CPU handles
	localparam int INT_WIDTH = 64;

	localparam logic [BF16_EXP_WIDTH-1:0] BF16_BIAS = 8'd127;
	// all-ones exponent marks infinity and NaN
	localparam logic [BF16_EXP_WIDTH-1:0] BF16_MAX_EXP = 8'd255;

	typedef struct packed
	{
		logic sign;
		logic [BF16_EXP_WIDTH-1:0] enc_exp;
		logic [BF16_MANT_WIDTH-1:0] enc_mantissa;
	} bf16_t;

	typedef enum logic [1:0]
	{
		TypSz8,
		TypSz16,
		TypSz32,
		TypSz64
	} type_size_e;

	typedef enum logic
	{
		OpFromInt,
		OpToInt
	} cast_op_e;

	typedef struct packed
	{
		cast_op_e op;
		// integer, or the bfloat16 in the low 16 bits
		logic [INT_WIDTH-1:0] operand;
		type_size_e type_size;
		logic type_signed;
	} cast_req_t;

	typedef struct packed
	{
		logic [INT_WIDTH-1:0] data;
		cast_op_e op;
	} cast_res_t;

	// ones over the bits that belong to the selected integer size
	function automatic logic [INT_WIDTH-1:0] type_mask(input type_size_e size);
		case (size)
		TypSz8: type_mask = 64'h0000_0000_0000_00ff;
		TypSz16: type_mask = 64'h0000_0000_0000_ffff;
		TypSz32: type_mask = 64'h0000_0000_ffff_ffff;
		default: type_mask = '1;
		endcase
	endfunction

	// sign position of the selected size, also the most negative value
	function automatic logic [INT_WIDTH-1:0] type_top_bit(input type_size_e size);
		logic [INT_WIDTH-1:0] mask;
		mask = type_mask(size);
		type_top_bit = mask & ~(mask >> 1);
	endfunction

endpackage

/* bf16_clz.sv */
`timescale 1ns/1ns

module bf16_clz
#(
	parameter int WIDTH = 64
)
(
	input logic [WIDTH-1:0] in,
	output logic [$clog2(WIDTH):0] count
);

	localparam int LEVELS = $clog2(WIDTH);

	// stage[LEVELS] is the raw input, stage[0] is fully left-justified
	logic [WIDTH-1:0] stage [0:LEVELS];
	// one count bit per halving test
	logic [LEVELS-1:0] hit;

	assign stage[LEVELS] = in;

	// widest test first, each one looks at the top 2**k bits
	for (genvar k = LEVELS - 1; k >= 0; k--)
	begin : g_level
		localparam int SPAN = 1 << k;

		assign hit[k] = (stage[k+1][WIDTH-1 -: SPAN] == '0);
		assign stage[k] = hit[k] ? (stage[k+1] << SPAN) : stage[k+1];
	end

	// a zero top bit after every shift means the input had no ones
	assign count = stage[0][WIDTH-1] ? {1'b0, hit} : (LEVELS + 1)'(WIDTH);

endmodule

/* bf16_from_int.sv */
`timescale 1ns/1ns

module bf16_from_int import bf16_cast_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic [INT_WIDTH-1:0] operand,
	input type_size_e type_size,
	input logic type_signed,
	output logic valid,
	output bf16_t data
);

	localparam int CLZ_WIDTH = $clog2(INT_WIDTH) + 1;

	typedef enum logic
	{
		StIdle,
		StFinishing
	} state_e;

	state_e state;

	logic [INT_WIDTH-1:0] mask;
	logic neg;
	logic [INT_WIDTH-1:0] abs_val;

	// captured on start
	logic [INT_WIDTH-1:0] mag_q;
	logic sign_q;

	// normalizer output
	logic [CLZ_WIDTH-1:0] lz;
	logic [INT_WIDTH-1:0] norm;
	logic [BF16_EXP_WIDTH-1:0] exp_q;
	logic [BF16_MANT_WIDTH-1:0] mant_q;
	logic zero_q;
	logic pack_q;

	assign mask = type_mask(type_size);
	assign neg = type_signed && ((operand & type_top_bit(type_size)) != '0);

	// sign-extend before negating so the most negative value stays exact
	assign abs_val = neg ? -(operand | ~mask) : (operand & mask);

	bf16_clz #(
		.WIDTH(INT_WIDTH)
	) clz_inst (
		.in(mag_q),
		.count(lz)
	);

	// leading one lands on the top bit
	assign norm = mag_q << lz;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= StIdle;
			pack_q <= 1'b0;
			valid <= 1'b0;
		end
		else
		begin
			valid <= pack_q;
			pack_q <= 1'b0;
			case (state)
			StIdle:
			begin
				if (start)
				begin
					state <= StFinishing;
				end
			end
			StFinishing:
			begin
				state <= StIdle;
				pack_q <= 1'b1;
			end
			default:
			begin
				state <= StIdle;
			end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state == StIdle) && start)
		begin
			mag_q <= abs_val;
			sign_q <= neg;
		end

		if (state == StFinishing)
		begin
			// leading one sits at bit 63 - lz
			exp_q <= BF16_BIAS + 8'(INT_WIDTH - 1) - 8'(lz);
			// bits below the leading one, truncated
			mant_q <= norm[INT_WIDTH-2 -: BF16_MANT_WIDTH];
			zero_q <= (mag_q == '0);
		end

		if (pack_q)
		begin
			if (zero_q)
			begin
				data <= '0;
			end
			else
			begin
				data.sign <= sign_q;
				data.enc_exp <= exp_q;
				data.enc_mantissa <= mant_q;
			end
		end
	end

endmodule

/* bf16_to_int.sv */
`timescale 1ns/1ns

module bf16_to_int import bf16_cast_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input bf16_t operand,
	input type_size_e type_size,
	input logic type_signed,
	output logic valid,
	output logic [INT_WIDTH-1:0] data
);

	typedef enum logic [1:0]
	{
		StIdle,
		StShift,
		StFinishing
	} state_e;

	state_e state;

	// captured on start
	bf16_t op_q;
	type_size_e size_q;
	logic signed_q;
	logic signed [8:0] exp_q;

	// shift stage results
	logic [INT_WIDTH-1:0] mag_q;
	logic ovf_q;
	logic fin_q;

	logic [INT_WIDTH-1:0] mask;
	logic [INT_WIDTH-1:0] top_bit;
	logic signed [8:0] limit;
	logic [INT_WIDTH-1:0] mag;
	logic [INT_WIDTH-1:0] result;

	assign mask = type_mask(size_q);
	assign top_bit = type_top_bit(size_q);

	// first unbiased exponent that no longer fits
	always_comb
	begin
		case (size_q)
		TypSz8: limit = 9'sd8;
		TypSz16: limit = 9'sd16;
		TypSz32: limit = 9'sd32;
		default: limit = 9'sd64;
		endcase
		// the sign bit costs one magnitude bit
		if (signed_q)
			limit = limit - 9'sd1;
	end

	// 1.mantissa placed at the top, then moved down by 63 - exp
	always_comb
	begin
		if (exp_q[8] || (op_q.enc_exp == '0))
			mag = '0;
		else
			mag = {1'b1, op_q.enc_mantissa, {(INT_WIDTH - 8){1'b0}}} >> (~exp_q[5:0]);
	end

	// saturation rules, then the sign
	always_comb
	begin
		if (signed_q)
		begin
			if (ovf_q)
				result = top_bit;
			else if (op_q.sign)
				result = -mag_q;
			else
				result = mag_q;
		end
		else
		begin
			// negative never maps to an unsigned value, even -inf
			if (op_q.sign)
				result = '0;
			else if (ovf_q)
				result = mask;
			else
				result = mag_q;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= StIdle;
			fin_q <= 1'b0;
			valid <= 1'b0;
		end
		else
		begin
			valid <= fin_q;
			fin_q <= 1'b0;
			case (state)
			StIdle:
			begin
				if (start)
				begin
					state <= StShift;
				end
			end
			StShift:
			begin
				state <= StFinishing;
			end
			StFinishing:
			begin
				state <= StIdle;
				fin_q <= 1'b1;
			end
			default:
			begin
				state <= StIdle;
			end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if ((state == StIdle) && start)
		begin
			op_q <= operand;
			size_q <= type_size;
			signed_q <= type_signed;
			exp_q <= $signed({1'b0, operand.enc_exp}) - $signed({1'b0, BF16_BIAS});
		end

		if (state == StShift)
		begin
			mag_q <= mag;
			ovf_q <= (op_q.enc_exp == BF16_MAX_EXP) || (exp_q >= limit);
		end

		// bits above the selected width are cleared
		if (state == StFinishing)
		begin
			data <= result & mask;
		end
	end

endmodule

/* bf16_cast_result.sv */
`timescale 1ns/1ns

module bf16_cast_result import bf16_cast_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input cast_op_e op,
	input logic from_valid,
	input bf16_t from_data,
	input logic to_valid,
	input logic [INT_WIDTH-1:0] to_data,
	output logic from_start,
	output logic to_start,
	output logic ready,
	output logic done,
	output cast_res_t res
);

	logic busy;
	cast_op_e pend_op;
	logic accept;
	logic eng_valid;
	logic [INT_WIDTH-1:0] eng_data;

	// starts while busy are dropped
	assign accept = start && !busy;
	assign ready = !busy;

	assign from_start = accept && (op == OpFromInt);
	assign to_start = accept && (op == OpToInt);

	// only the engine that got the command is listened to
	assign eng_valid = (pend_op == OpFromInt) ? from_valid : to_valid;
	assign eng_data = (pend_op == OpFromInt) ?
		{{(INT_WIDTH - 16){1'b0}}, from_data} : to_data;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			pend_op <= OpFromInt;
			done <= 1'b0;
			res <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (accept)
			begin
				busy <= 1'b1;
				pend_op <= op;
			end
			else if (busy && eng_valid)
			begin
				busy <= 1'b0;
				done <= 1'b1;
				res.data <= eng_data;
				res.op <= pend_op;
			end
		end
	end

endmodule

/* bf16_cast_unit.sv */
`timescale 1ns/1ns

module bf16_cast_unit import bf16_cast_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input cast_req_t req,
	output logic ready,
	output logic done,
	output cast_res_t res
);

	logic from_start;
	logic to_start;
	logic from_valid;
	logic to_valid;
	bf16_t from_data;
	logic [INT_WIDTH-1:0] to_data;

	bf16_from_int from_int_inst (
		.clk(clk),
		.rst(rst),
		.start(from_start),
		.operand(req.operand),
		.type_size(req.type_size),
		.type_signed(req.type_signed),
		.valid(from_valid),
		.data(from_data)
	);

	// the bfloat16 rides in the low half-word of the operand
	bf16_to_int to_int_inst (
		.clk(clk),
		.rst(rst),
		.start(to_start),
		.operand(req.operand[15:0]),
		.type_size(req.type_size),
		.type_signed(req.type_signed),
		.valid(to_valid),
		.data(to_data)
	);

	bf16_cast_result result_inst (
		.clk(clk),
		.rst(rst),
		.start(start),
		.op(req.op),
		.from_valid(from_valid),
		.from_data(from_data),
		.to_valid(to_valid),
		.to_data(to_data),
		.from_start(from_start),
		.to_start(to_start),
		.ready(ready),
		.done(done),
		.res(res)
	);

endmodule

/* tb_bf16_cast_checker.sv */
`timescale 1ns/1ns

module tb_bf16_cast_checker import bf16_cast_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic start,
	input cast_req_t req,
	input logic ready,
	input logic done,
	input cast_res_t res,
	input logic exp_use,
	input logic [INT_WIDTH-1:0] exp_data,
	output int errors,
	output int checks
);

	logic pending;
	cast_op_e pend_op;
	logic [INT_WIDTH-1:0] want;
	int cycles;
	int latency;
	logic rst_prev;

	function automatic int size_bits(input type_size_e size);
		case (size)
		TypSz8: return 8;
		TypSz16: return 16;
		TypSz32: return 32;
		default: return 64;
		endcase
	endfunction

	function automatic logic [63:0] low_ones(input int w);
		return (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
	endfunction

	// exponent 127 plus leading one position, next seven bits truncated
	function automatic logic [63:0] model_from_int(input cast_req_t r);
		logic [63:0] mag;
		logic [6:0] mant;
		logic neg;
		int w;
		int p;
		w = size_bits(r.type_size);
		mag = r.operand & low_ones(w);
		neg = r.type_signed && mag[w-1];
		if (neg)
			mag = (~mag + 64'd1) & low_ones(w);
		if (mag == '0)
			return '0;
		p = 63;
		while (!mag[p])
			p--;
		if (p >= 7)
			mant = 7'(mag >> (p - 7));
		else
			mant = 7'(mag << (7 - p));
		return {48'd0, neg, 8'(127 + p), mant};
	endfunction

	function automatic logic [63:0] model_to_int(input cast_req_t r);
		logic [15:0] f;
		logic [63:0] ones;
		logic [63:0] mag;
		logic ovf;
		int w;
		int k;
		f = r.operand[15:0];
		w = size_bits(r.type_size);
		ones = low_ones(w);
		k = int'(f[14:7]) - 127;
		ovf = (f[14:7] == 8'hff) || (k >= (w - int'(r.type_signed)));
		if ((f[14:7] == 8'h00) || (k < 0))
			mag = '0;
		else if (k >= 7)
			mag = {56'd0, 1'b1, f[6:0]} << (k - 7);
		else
			mag = {56'd0, 1'b1, f[6:0]} >> (7 - k);
		if (r.type_signed)
			return ovf ? (64'd1 << (w - 1)) : (f[15] ? (-mag & ones) : mag);
		// unsigned: negatives clamp to zero first
		return f[15] ? '0 : (ovf ? ones : mag);
	endfunction

	always @(posedge clk)
	begin
		if (rst)
		begin
			pending = 1'b0;
			errors = 0;
			checks = 0;
		end
		else
		begin
			if (rst_prev && (!ready || done || (res !== '0)))
			begin
				$display("** Error at %0t: ready=%b done=%b res=%h after reset, expected 1 0 0",
					$time, ready, done, res);
				errors++;
			end
			if (pending && !done && ready)
			begin
				$display("** Error at %0t: ready=%b while busy, expected 0", $time, ready);
				errors++;
			end
			if (done)
			begin
				checks++;
				latency = (pend_op == OpFromInt) ? 3 : 4;
				if (!pending)
				begin
					$display("%0t: done arrived with no command pending", $time);
					errors++;
				end
				else
				begin
					if (res.data !== want)
					begin
						$display("** Error at %0t: res.data=%h, expected %h",
							$time, res.data, want);
						errors++;
					end
					if (res.op !== pend_op)
					begin
						$display("** Error at %0t: res.op=%b, expected %b",
							$time, res.op, pend_op);
						errors++;
					end
					if (cycles != latency)
					begin
						$display("** Error at %0t: done latency=%0d, expected %0d",
							$time, cycles, latency);
						errors++;
					end
				end
				pending = 1'b0;
			end
			else if (pending)
			begin
				cycles++;
			end
			// a new command can be accepted on the same edge as done
			if (start && ready)
			begin
				pending = 1'b1;
				pend_op = req.op;
				cycles = 0;
				if (exp_use)
					want = exp_data;
				else if (req.op == OpFromInt)
					want = model_from_int(req);
				else
					want = model_to_int(req);
			end
		end
		rst_prev = rst;
	end

endmodule

/* tb_bf16_cast_assert.sv */
`timescale 1ns/1ns

module tb_bf16_cast_assert
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic ready,
	input logic done,
	input logic from_start,
	input logic to_start
);

	int fails = 0;
	logic pending;

	// set by an accepted start and cleared by done
	always_ff @(posedge clk)
	begin
		if (rst)
			pending <= 1'b0;
		else if (start && ready)
			pending <= 1'b1;
		else if (done)
			pending <= 1'b0;
	end

	a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
	else
	begin
		fails++;
		$error("done stayed high for more than one cycle");
	end

	a_ready_low: assert property (@(posedge clk) disable iff (rst) (pending && !done) |-> !ready)
	else
	begin
		fails++;
		$error("ready high while a command is pending");
	end

	// one engine per command, and never while the previous one is still out
	a_one_engine: assert property (@(posedge clk) disable iff (rst)
		(from_start || to_start) |-> ((from_start != to_start) && (!pending || done)))
	else
	begin
		fails++;
		$error("engine started twice or while a command was pending");
	end

endmodule

bind bf16_cast_unit tb_bf16_cast_assert assert_inst (
	.clk(clk),
	.rst(rst),
	.start(start),
	.ready(ready),
	.done(done),
	.from_start(from_start),
	.to_start(to_start)
);

/* tb_bf16_cast_unit.sv */
`timescale 1ns/1ns

module tb_bf16_cast_unit import bf16_cast_pkg::*;
();

	localparam int NUM_ROWS = 26;
	localparam int NUM_RANDOM = 20;
	localparam int WAIT_LIMIT = 40;

	typedef struct packed
	{
		cast_op_e op;
		logic [INT_WIDTH-1:0] operand;
		type_size_e size;
		logic sgn;
		logic [INT_WIDTH-1:0] want;
	} row_t;

	row_t rows [0:NUM_ROWS-1] = '{
		// integer to bfloat16, unsigned
		'{OpFromInt, 64'h0000_0000_0000_0000, TypSz8, 1'b0, 64'h0000},
		'{OpFromInt, 64'h0000_0000_0000_00ff, TypSz8, 1'b0, 64'h437f},
		'{OpFromInt, 64'h0000_0000_0000_1234, TypSz16, 1'b0, 64'h4591},
		'{OpFromInt, 64'hdead_beef_8000_0001, TypSz32, 1'b0, 64'h4f00},
		'{OpFromInt, 64'hffff_ffff_ffff_ffff, TypSz64, 1'b0, 64'h5f7f},
		'{OpFromInt, 64'h0000_0000_0000_0001, TypSz64, 1'b0, 64'h3f80},
		// signed, most negative value of each size
		'{OpFromInt, 64'h0000_0000_0000_0080, TypSz8, 1'b1, 64'hc300},
		'{OpFromInt, 64'h1234_5678_9abc_defe, TypSz8, 1'b1, 64'hc000},
		'{OpFromInt, 64'h0000_0000_0000_8000, TypSz16, 1'b1, 64'hc700},
		'{OpFromInt, 64'h0000_0000_0000_7fff, TypSz16, 1'b1, 64'h46ff},
		'{OpFromInt, 64'h0000_0000_8000_0000, TypSz32, 1'b1, 64'hcf00},
		'{OpFromInt, 64'h8000_0000_0000_0000, TypSz64, 1'b1, 64'hdf00},
		'{OpFromInt, 64'hffff_ffff_ffff_ff9c, TypSz64, 1'b1, 64'hc2c8},
		// bfloat16 to integer, in range
		'{OpToInt, 64'h5f00, TypSz64, 1'b0, 64'h8000_0000_0000_0000},
		'{OpToInt, 64'h42c8, TypSz8, 1'b0, 64'h64},
		'{OpToInt, 64'hc2c8, TypSz8, 1'b1, 64'h9c},
		'{OpToInt, 64'h3f00, TypSz16, 1'b0, 64'h0},
		'{OpToInt, 64'hc0a0, TypSz64, 1'b1, 64'hffff_ffff_ffff_fffb},
		'{OpToInt, 64'h40f0, TypSz32, 1'b0, 64'h7},
		'{OpToInt, 64'h437f, TypSz8, 1'b0, 64'hff},
		// saturation
		'{OpToInt, 64'h4300, TypSz8, 1'b1, 64'h80},
		'{OpToInt, 64'hbf80, TypSz16, 1'b0, 64'h0},
		'{OpToInt, 64'h4780, TypSz16, 1'b0, 64'hffff},
		'{OpToInt, 64'h7f80, TypSz32, 1'b1, 64'h8000_0000},
		'{OpToInt, 64'h7fc0, TypSz64, 1'b0, 64'hffff_ffff_ffff_ffff},
		'{OpToInt, 64'hff80, TypSz16, 1'b1, 64'h8000}
	};

	logic clk;
	logic rst;
	logic start;
	cast_req_t req;
	logic ready;
	logic done;
	cast_res_t res;
	logic exp_use;
	logic [INT_WIDTH-1:0] exp_data;
	int errors;
	int checks;
	int timeouts;
	int issued;
	int asserts;
	integer seed;

	always #4 clk = ~clk;

	bf16_cast_unit bf16_cast_unit_inst (
		.clk(clk),
		.rst(rst),
		.start(start),
		.req(req),
		.ready(ready),
		.done(done),
		.res(res)
	);

	tb_bf16_cast_checker checker_inst (
		.clk(clk),
		.rst(rst),
		.start(start),
		.req(req),
		.ready(ready),
		.done(done),
		.res(res),
		.exp_use(exp_use),
		.exp_data(exp_data),
		.errors(errors),
		.checks(checks)
	);

	task automatic wait_ready(output logic ok);
		int n;
		ok = 1'b0;
		n = 0;
		while (!ok && (n < WAIT_LIMIT))
		begin
			if (ready)
				ok = 1'b1;
			else
				@(negedge clk);
			n++;
		end
	endtask

	task automatic wait_done(output logic ok);
		int n;
		ok = 1'b0;
		n = 0;
		while (!ok && (n < WAIT_LIMIT))
		begin
			@(negedge clk);
			ok = done;
			n++;
		end
	endtask

	task automatic run_cmd(input cast_op_e op, input logic [INT_WIDTH-1:0] operand,
		input type_size_e size, input logic sgn, input logic use_want,
		input logic [INT_WIDTH-1:0] want, input logic poke, output logic ok);
		wait_ready(ok);
		if (!ok)
		begin
			$display("%0t: timeout while waiting for ready", $time);
			timeouts++;
		end
		else
		begin
			req.op = op;
			req.operand = operand;
			req.type_size = size;
			req.type_signed = sgn;
			exp_use = use_want;
			exp_data = want;
			start = 1'b1;
			issued++;
			@(negedge clk);
			start = 1'b0;
			// a second start while busy has to be dropped
			if (poke)
			begin
				start = 1'b1;
				@(negedge clk);
				start = 1'b0;
			end
			wait_done(ok);
			if (!ok)
			begin
				$display("%0t: timeout while waiting for done", $time);
				timeouts++;
			end
		end
	endtask

	initial
	begin
		logic ok;
		int i;
		logic [31:0] rnd_bits;
		logic [INT_WIDTH-1:0] rnd_operand;
		cast_op_e rnd_op;
		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		req = '0;
		exp_use = 1'b0;
		exp_data = '0;
		seed = 32'hebc8;
		timeouts = 0;
		issued = 0;
		ok = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		for (i = 0; (i < NUM_ROWS) && ok; i++)
			run_cmd(rows[i].op, rows[i].operand, rows[i].size, rows[i].sgn,
				1'b1, rows[i].want, (i == 3) || (i == 16), ok);

		// random commands, checker works out the result
		for (i = 0; (i < NUM_RANDOM) && ok; i++)
		begin
			rnd_bits = $random(seed);
			rnd_operand = {$random(seed), $random(seed)};
			rnd_op = rnd_bits[16] ? OpToInt : OpFromInt;
			if (rnd_op == OpToInt)
				rnd_operand[14:7] = 8'd120 + (rnd_bits[7:0] % 8'd72);
			else
				rnd_operand = rnd_operand >> rnd_bits[13:8];
			run_cmd(rnd_op, rnd_operand, type_size_e'(rnd_bits[18:17]), rnd_bits[19],
				1'b0, '0, 1'b0, ok);
		end

		// the checker samples the last done on the next rising edge
		@(posedge clk);
		@(negedge clk);
		asserts = bf16_cast_unit_inst.assert_inst.fails;
		$display("errors: %0d, assertion failures: %0d, timeouts: %0d, results: %0d of %0d",
			errors, asserts, timeouts, checks, issued);
		if ((errors == 0) && (asserts == 0) && (timeouts == 0) && (checks == issued))
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* bf16_cast_unit.f */
bf16_cast_pkg.sv
bf16_clz.sv
bf16_from_int.sv
bf16_to_int.sv
bf16_cast_result.sv
bf16_cast_unit.sv
tb_bf16_cast_checker.sv
tb_bf16_cast_assert.sv
tb_bf16_cast_unit.sv

/* Bender.yml */
package:
  name: bf16_cast_unit

sources:
  - bf16_cast_pkg.sv
  - bf16_clz.sv
  - bf16_from_int.sv
  - bf16_to_int.sv
  - bf16_cast_result.sv
  - bf16_cast_unit.sv
  - target: test
    files:
      - tb_bf16_cast_checker.sv
      - tb_bf16_cast_assert.sv
      - tb_bf16_cast_unit.sv
